//--- filelist.f
logic/memBusPkg.sv
logic/spiConsolePkg.sv
logic/consoleStoreUnpack.sv
logic/consoleFifo.sv
logic/spiByteShifter.sv
logic/spiConsole.sv
tb/spiConsoleTb.sv

//--- logic/consoleFifo.sv
module consoleFifo (
    input  logic                     SPI_clk,
    input  logic                     arstN,
    input  spiConsolePkg::byteBeat_t push,
    input  logic                     pop,
    output spiConsolePkg::byteBeat_t head,
    output logic                     creditReturn
);

    logic [7:0]                          mem [spiConsolePkg::QUEUE_DEPTH];
    logic [spiConsolePkg::PTR_W-1:0]    wrPtr;
    logic [spiConsolePkg::PTR_W-1:0]    rdPtr;
    logic [spiConsolePkg::CREDIT_W-1:0] count;

    assign head.valid = count != '0;
    assign head.data  = mem[rdPtr];

    always_ff @(posedge SPI_clk) begin
        if (push.valid) begin
            mem[wrPtr] <= push.data;
        end
    end

    // Pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge SPI_clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (push.valid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge SPI_clk or negedge arstN) begin
        if (!arstN) begin
            count        <= '0;
            creditReturn <= 1'b0;
        end else begin
            creditReturn <= pop;  // Freed slot goes back to the producer.
            case ({push.valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Holds only if the producer respects its credit count.
    assert property (@(posedge SPI_clk) disable iff (!arstN)
        push.valid |-> (count != spiConsolePkg::CREDIT_MAX))
        else $error("Byte pushed into a full console queue.");

    assert property (@(posedge SPI_clk) disable iff (!arstN)
        pop |-> head.valid)
        else $error("Shifter popped an empty console queue.");

endmodule

//--- logic/consoleStoreUnpack.sv
module consoleStoreUnpack (
    input  logic                     SPI_clk,
    input  logic                     arstN,
    input  memBusPkg::storeReq_t     store,
    output logic                     storeBusy,
    output spiConsolePkg::byteBeat_t push,
    input  logic                     creditReturn
);

    logic [3:0]                          laneMask;
    logic [3:0]                          maskAfterPush;
    logic [31:0]                         wordData;
    logic [1:0]                          laneSel;
    logic [spiConsolePkg::CREDIT_W-1:0] credits;
    logic                                accept;

    // Stores elsewhere, or with no lanes enabled, fall through without effect.
    assign accept = store.valid && !storeBusy
                    && (store.addr == memBusPkg::CONSOLE_ADDR)
                    && (store.wm != 4'b0000);

    // Scan from the top so the lowest set lane wins.
    always_comb begin
        laneSel = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (laneMask[i]) begin
                laneSel = 2'(i);
            end
        end
    end

    assign maskAfterPush = laneMask & (laneMask - 4'd1);  // Clears the lowest set bit.

    assign push.valid = storeBusy && (credits != '0);
    assign push.data  = wordData[{laneSel, 3'b000} +: 8];

    always_ff @(posedge SPI_clk or negedge arstN) begin
        if (!arstN) begin
            storeBusy <= 1'b0;
            laneMask  <= 4'b0000;
        end else if (accept) begin
            storeBusy <= 1'b1;
            laneMask  <= store.wm;
        end else if (push.valid) begin
            laneMask  <= maskAfterPush;
            storeBusy <= maskAfterPush != 4'b0000;  // Drops with the last lane.
        end
    end

    always_ff @(posedge SPI_clk) begin
        if (accept) begin
            wordData <= store.data;
        end
    end

    // One credit per free queue slot, handed back by the FIFO on each pop.
    always_ff @(posedge SPI_clk or negedge arstN) begin
        if (!arstN) begin
            credits <= spiConsolePkg::CREDIT_MAX;
        end else begin
            case ({push.valid, creditReturn})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // A FIFO that returns more credits than it received pops breaks this.
    assert property (@(posedge SPI_clk) disable iff (!arstN)
        credits <= spiConsolePkg::CREDIT_MAX)
        else $error("Credit count rose above the queue depth.");

endmodule

//--- logic/memBusPkg.sv
package memBusPkg;

    // One store request as the core issues it on its data port.
    typedef struct packed {
        logic        valid;
        logic [3:0]  wm;    // Bit n enables data bits 8n+7 to 8n.
        logic [29:0] addr;  // Word address, so byte address bits 1:0 are dropped.
        logic [31:0] data;
    } storeReq_t;

    // Word address of the console data register, byte address 0xFFFF_FC00.
    localparam logic [29:0] CONSOLE_ADDR = 30'h3FFF_FF00;

endpackage

//--- logic/spiByteShifter.sv
module spiByteShifter (
    input  logic                     SPI_clk,
    input  logic                     arstN,
    input  spiConsolePkg::byteBeat_t head,
    output logic                     pop,
    output spiConsolePkg::spiPins_t  spi
);

    typedef enum logic [1:0] {
        stIdle,
        stShift,
        stGap
    } shiftState_t;

    shiftState_t                      state;
    logic [spiConsolePkg::DIV_W-1:0] divCnt;
    logic [2:0]                       bitCnt;
    logic [7:0]                       shiftReg;
    logic                             csN;
    logic                             sclk;
    logic                             halfDone;

    assign halfDone = divCnt == spiConsolePkg::DIV_LAST;
    assign pop      = (state == stIdle) && head.valid;

    assign spi.csN  = csN;
    assign spi.sclk = sclk;
    assign spi.mosi = shiftReg[7];  // Zero fill keeps mosi low between frames.

    always_ff @(posedge SPI_clk or negedge arstN) begin
        if (!arstN) begin
            state    <= stIdle;
            divCnt   <= '0;
            bitCnt   <= 3'd0;
            shiftReg <= 8'h00;
            csN      <= 1'b1;
            sclk     <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    if (pop) begin
                        shiftReg <= head.data;  // Bit 7 is on mosi as csN falls.
                        csN      <= 1'b0;
                        divCnt   <= '0;
                        bitCnt   <= 3'd0;
                        state    <= stShift;
                    end
                end
                stShift: begin
                    if (halfDone) begin
                        divCnt <= '0;
                        sclk   <= ~sclk;
                        if (sclk) begin
                            // Falling edge, so the next bit goes out.
                            shiftReg <= {shiftReg[6:0], 1'b0};
                            bitCnt   <= bitCnt + 1'b1;
                            if (bitCnt == 3'd7) begin
                                csN   <= 1'b1;
                                state <= stGap;
                            end
                        end
                    end else begin
                        divCnt <= divCnt + 1'b1;
                    end
                end
                stGap: begin
                    if (halfDone) begin
                        divCnt <= '0;
                        state  <= stIdle;
                    end else begin
                        divCnt <= divCnt + 1'b1;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    assert property (@(posedge SPI_clk) disable iff (!arstN)
        (state == stIdle && !pop) |-> spi.csN)
        else $error("Chip select low while the shifter has no byte.");

    // A frame opens with sclk low, as mode 0 requires.
    assert property (@(posedge SPI_clk) disable iff (!arstN)
        pop |=> (!spi.csN && !spi.sclk))
        else $error("Frame did not open with csN low and sclk low.");

endmodule

//--- logic/spiConsole.sv
module spiConsole (
    input  logic                    SPI_clk,
    input  logic                    arstN,
    input  memBusPkg::storeReq_t    store,
    output logic                    storeBusy,
    output spiConsolePkg::spiPins_t spi
);

    spiConsolePkg::byteBeat_t push;
    spiConsolePkg::byteBeat_t head;
    logic                     creditReturn;
    logic                     pop;

    // Splits console stores into bytes.
    consoleStoreUnpack unpackInst (
        .SPI_clk      (SPI_clk),
        .arstN        (arstN),
        .store        (store),
        .storeBusy    (storeBusy),
        .push         (push),
        .creditReturn (creditReturn)
    );

    consoleFifo fifoInst (
        .SPI_clk      (SPI_clk),
        .arstN        (arstN),
        .push         (push),
        .pop          (pop),
        .head         (head),
        .creditReturn (creditReturn)
    );

    // One mode-0 frame per byte.
    spiByteShifter shifterInst (
        .SPI_clk (SPI_clk),
        .arstN   (arstN),
        .head    (head),
        .pop     (pop),
        .spi     (spi)
    );

endmodule

//--- logic/spiConsolePkg.sv
package spiConsolePkg;

    localparam int QUEUE_DEPTH = 8;                 // Bytes held between the unpacker and the SPI link.
    localparam int PTR_W = $clog2(QUEUE_DEPTH);     // Must stay a power of two for pointer wrap.
    localparam int CREDIT_W = 4;                    // Holds 0 to QUEUE_DEPTH inclusive.
    localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(QUEUE_DEPTH);

    localparam int SPI_HALF = 2;                    // SPI_clk cycles per sclk half period.
    localparam int DIV_W = $clog2(SPI_HALF + 1);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SPI_HALF - 1);

    // Pins toward the console device.
    typedef struct packed {
        logic csN;
        logic sclk;
        logic mosi;
    } spiPins_t;

    // A single byte moving between stages.
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } byteBeat_t;

endpackage

//--- run.sh
#!/bin/sh
# Builds the SPI console testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f filelist.f --top-module spiConsoleTb -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- tb/spiConsoleTb.sv
module spiConsoleTb;

    logic                    SPI_clk;
    logic                    arstN;
    memBusPkg::storeReq_t    store;
    logic                    storeBusy;
    spiConsolePkg::spiPins_t spi;

    logic [7:0]  expQ [$];  // Bytes still owed on the SPI link, oldest first.
    string       testName;
    int          mismatchCount;
    int          failCount;
    int          rxCount;
    int          lastBusy;
    logic        timedOut;
    logic [31:0] lcgState;
    logic [7:0]  rxShift;
    int          rxBits;
    logic        prevSclk;
    logic        prevCsN;

    spiConsole spiConsole_inst (
        .SPI_clk   (SPI_clk),
        .arstN     (arstN),
        .store     (store),
        .storeBusy (storeBusy),
        .spi       (spi)
    );

    initial begin
        SPI_clk = 1'b0;
        forever #4 SPI_clk = ~SPI_clk;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    task automatic finishRun();
        $display("Errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
        if (mismatchCount == 0 && failCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    // Once a wait has run out, the remaining waits are skipped.
    task automatic reportTimeout(input string what);
        $display("Timeout in %s: %s", testName, what);
        failCount++;
        timedOut = 1'b1;
    endtask

    task automatic checkByte(input logic [7:0] got, input int bits);
        logic [7:0] want;
        assert (bits == 8) else begin
            $display("A frame in %s carried %0d sclk pulses instead of 8.", testName, bits);
            failCount++;
        end
        assert (expQ.size() > 0) else begin
            $display("Byte %02h arrived in %s while no byte was expected.", got, testName);
            failCount++;
        end
        if (expQ.size() > 0) begin
            want = expQ.pop_front();
            assert (got == want) else begin
                $display("mismatch %s: expected %02h, actual %02h", testName, want, got);
                mismatchCount++;
            end
        end
        rxCount++;
    endtask

    task automatic checkBusy(input int expected);
        if (!timedOut) begin
            assert (lastBusy == expected) else begin
                $display("mismatch %s storeBusy cycles: expected %0d, actual %0d",
                         testName, expected, lastBusy);
                mismatchCount++;
            end
        end
    endtask

    // Drives one store for a single cycle and counts the busy cycles that follow it.
    task automatic sendStore(input logic [29:0] addr, input logic [3:0] wm,
                             input logic [31:0] data);
        if (timedOut) begin
            return;
        end
        @(posedge SPI_clk);
        store <= '{valid: 1'b1, wm: wm, addr: addr, data: data};
        if (addr == memBusPkg::CONSOLE_ADDR && wm != 4'b0000) begin
            for (int i = 0; i < 4; i++) begin
                if (wm[i]) begin
                    expQ.push_back(data[8*i +: 8]);
                end
            end
        end
        @(posedge SPI_clk);
        store.valid <= 1'b0;  // Busy was low, so the store is taken on this edge.
        lastBusy = 0;
        @(negedge SPI_clk);
        while (storeBusy) begin
            if (lastBusy == 4000) begin
                reportTimeout("storeBusy never dropped after a store.");
                return;
            end
            lastBusy++;
            @(negedge SPI_clk);
        end
    endtask

    // The link is drained once csN stays high well past the gap between frames.
    task automatic waitDrained();
        int cycles;
        int quiet;
        if (timedOut) begin
            return;
        end
        cycles = 0;
        quiet  = 0;
        while (quiet < 16) begin
            if (cycles == 4000) begin
                reportTimeout("the SPI link never went quiet.");
                return;
            end
            cycles++;
            @(negedge SPI_clk);
            quiet = spi.csN ? quiet + 1 : 0;
        end
        assert (expQ.size() == 0) else begin
            $display("%0d expected bytes never came out on the SPI link in %s.",
                     expQ.size(), testName);
            failCount++;
        end
    endtask

    // SPI receiver. The pins are registered on SPI_clk, so the falling edge sees them settled.
    always @(negedge SPI_clk) begin
        if (!arstN) begin
            prevSclk = 1'b0;
            prevCsN  = 1'b1;
            rxShift  = 8'h00;
            rxBits   = 0;
        end else begin
            if (!spi.csN && prevCsN) begin
                rxBits = 0;
            end
            if (!spi.csN && spi.sclk && !prevSclk) begin
                rxShift = {rxShift[6:0], spi.mosi};  // Most significant bit arrives first.
                rxBits++;
            end
            if (spi.csN && !prevCsN) begin
                checkByte(rxShift, rxBits);
            end
            prevSclk = spi.sclk;
            prevCsN  = spi.csN;
        end
    end

    initial begin
        int          startCount;
        int          maxBusy;
        logic [31:0] r;
        logic [29:0] addr;
        lcgState      = 32'd26;
        mismatchCount = 0;
        failCount     = 0;
        rxCount       = 0;
        lastBusy      = 0;
        timedOut      = 1'b0;
        testName      = "reset";
        arstN <= 1'b0;
        store <= '0;
        repeat (16) @(posedge SPI_clk);
        arstN <= 1'b1;
        @(negedge SPI_clk);
        assert (spi.csN == 1'b1 && spi.sclk == 1'b0 && storeBusy == 1'b0) else begin
            $display("SPI pins or storeBusy were not idle after reset.");
            failCount++;
        end

        testName = "fullWord";
        sendStore(memBusPkg::CONSOLE_ADDR, 4'b1111, 32'hA1B2C3D4);
        checkBusy(4);
        waitDrained();

        testName = "partialMask";
        sendStore(memBusPkg::CONSOLE_ADDR, 4'b0001, 32'h11223344);
        checkBusy(1);
        sendStore(memBusPkg::CONSOLE_ADDR, 4'b0110, 32'h55667788);
        checkBusy(2);
        sendStore(memBusPkg::CONSOLE_ADDR, 4'b1000, 32'h99AABBCC);
        checkBusy(1);
        waitDrained();

        testName   = "ignored";
        startCount = rxCount;
        sendStore(memBusPkg::CONSOLE_ADDR + 30'd1, 4'b1111, 32'hDEADBEEF);
        checkBusy(0);
        sendStore(memBusPkg::CONSOLE_ADDR, 4'b0000, 32'hCAFEF00D);
        checkBusy(0);
        repeat (40) @(negedge SPI_clk);
        assert (rxCount == startCount) else begin
            $display("A frame went out on the SPI link for an ignored store.");
            failCount++;
        end

        testName = "backPressure";
        maxBusy  = 0;
        for (int s = 0; s < 8; s++) begin
            sendStore(memBusPkg::CONSOLE_ADDR, 4'b1111, nextRandom());
            if (lastBusy > maxBusy) begin
                maxBusy = lastBusy;
            end
        end
        assert (maxBusy > 4) else begin
            $display("storeBusy never stretched although the queue ran out of credits.");
            failCount++;
        end
        waitDrained();

        testName = "randomStream";
        for (int s = 0; s < 40; s++) begin
            r    = nextRandom();
            addr = (r[31:29] == 3'b000) ? memBusPkg::CONSOLE_ADDR + 30'd4
                                        : memBusPkg::CONSOLE_ADDR;
            sendStore(addr, r[11:8], nextRandom());
        end
        waitDrained();
        finishRun();
    end

endmodule
